//--- hdl/dma_pkg.sv
package dma_pkg;

  ////////////////////////////////
  // Widths
  ////////////////////////////////

  localparam int ADDR_W = 32;  // Local byte address
  localparam int DATA_W = 32;  // One bus word, one flit payload
  localparam int LEN_W  = 8;   // Transfer length in words
  localparam int TILE_W = 8;   // Tile identifier
  localparam int POS_W  = 4;   // Table index, up to 16 entries

  ////////////////////////////////
  // NoC flit and header layout
  ////////////////////////////////

  typedef struct packed {
    logic              first;  // Header flit
    logic              last;   // Closes the packet
    logic [DATA_W-1:0] data;
  } flit_t;

  // Payload of the header flit
  typedef struct packed {
    logic [TILE_W-1:0]                dest;
    logic [TILE_W-1:0]                src;
    logic [DATA_W-2*TILE_W-LEN_W-1:0] rsvd;  // Sent as zero
    logic [LEN_W-1:0]                 len;
  } hdr_t;

  ////////////////////////////////
  // Descriptor and local bus
  ////////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] laddr;  // Local source
    logic [ADDR_W-1:0] raddr;  // Remote destination
    logic [LEN_W-1:0]  len;
    logic [TILE_W-1:0] dest;
  } desc_t;

  typedef struct packed {
    logic              sel;
    logic              write;
    logic              lock;  // Held over a whole packet
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  ////////////////////////////////
  // Register map, 16 bytes per entry
  ////////////////////////////////

  localparam logic [3:0] REG_LADDR    = 4'h0;
  localparam logic [3:0] REG_RADDR    = 4'h4;
  localparam logic [3:0] REG_CTRL_LEN = 4'h8;
  localparam logic [3:0] REG_STATUS   = 4'hc;

  localparam int CTRL_LEN_LSB  = 0;
  localparam int CTRL_DEST_LSB = 8;
  localparam int CTRL_START    = 31;  // Write one to launch
  localparam int STATUS_VALID  = 0;
  localparam int STATUS_DONE   = 1;

endpackage

//--- hdl/dma_request_table.sv
module dma_request_table #(
  parameter int TABLE_ENTRIES = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  dma_pkg::bus_req_t           cfg_req,
  output dma_pkg::bus_rsp_t           cfg_rsp,
  output dma_pkg::desc_t              sel_desc,
  output logic                        sel_valid,
  output logic [dma_pkg::POS_W-1:0]   sel_pos,
  input  logic                        done_en,
  input  logic [dma_pkg::POS_W-1:0]   done_pos,
  output logic [TABLE_ENTRIES-1:0]    irq
);

  localparam int IDX_W = (TABLE_ENTRIES > 1) ? $clog2(TABLE_ENTRIES) : 1;

  dma_pkg::desc_t           desc [TABLE_ENTRIES];
  logic [TABLE_ENTRIES-1:0] valid;
  logic [TABLE_ENTRIES-1:0] done;
  logic [TABLE_ENTRIES-1:0] active;   // Handed to the initiator
  logic [TABLE_ENTRIES-1:0] irq_q;
  logic [IDX_W-1:0]         cfg_idx;
  logic [IDX_W-1:0]         done_idx;
  logic [IDX_W-1:0]         pick;
  logic [3:0]               cfg_off;
  logic                     cfg_wr;
  logic                     start;
  logic                     pend;

  ////////////////////////////////
  // Register decode
  ////////////////////////////////

  assign cfg_off  = cfg_req.addr[3:0];
  assign cfg_idx  = (TABLE_ENTRIES > 1) ? cfg_req.addr[4 +: IDX_W] : '0;
  assign done_idx = done_pos[IDX_W-1:0];
  assign cfg_wr   = cfg_req.sel && cfg_req.write;
  assign start    = cfg_wr && (cfg_off == dma_pkg::REG_CTRL_LEN)
                    && cfg_req.wdata[dma_pkg::CTRL_START];

  // Descriptor fields
  always_ff @(posedge clk) begin
    if (cfg_wr) begin
      case (cfg_off)
        dma_pkg::REG_LADDR: desc[cfg_idx].laddr <= cfg_req.wdata;
        dma_pkg::REG_RADDR: desc[cfg_idx].raddr <= cfg_req.wdata;
        dma_pkg::REG_CTRL_LEN: begin
          desc[cfg_idx].len  <= cfg_req.wdata[dma_pkg::CTRL_LEN_LSB +: dma_pkg::LEN_W];
          desc[cfg_idx].dest <= cfg_req.wdata[dma_pkg::CTRL_DEST_LSB +: dma_pkg::TILE_W];
        end
        default: ;  // Status is read only
      endcase
    end
  end

  // Single cycle access with read data straight from the array
  always_comb begin
    cfg_rsp.ready = 1'b1;
    cfg_rsp.rdata = '0;
    case (cfg_off)
      dma_pkg::REG_LADDR: cfg_rsp.rdata = desc[cfg_idx].laddr;
      dma_pkg::REG_RADDR: cfg_rsp.rdata = desc[cfg_idx].raddr;
      dma_pkg::REG_CTRL_LEN: begin
        cfg_rsp.rdata[dma_pkg::CTRL_LEN_LSB +: dma_pkg::LEN_W]   = desc[cfg_idx].len;
        cfg_rsp.rdata[dma_pkg::CTRL_DEST_LSB +: dma_pkg::TILE_W] = desc[cfg_idx].dest;
      end
      dma_pkg::REG_STATUS: begin
        cfg_rsp.rdata[dma_pkg::STATUS_VALID] = valid[cfg_idx];
        cfg_rsp.rdata[dma_pkg::STATUS_DONE]  = done[cfg_idx];
      end
      default: ;
    endcase
  end

  ////////////////////////////////
  // Entry selection
  ////////////////////////////////

  // Descending scan so the lowest pending index wins
  always_comb begin
    pick = '0;
    pend = 1'b0;
    for (int i = TABLE_ENTRIES - 1; i >= 0; i--) begin
      if (valid[i] && !active[i]) begin
        pick = IDX_W'(i);
        pend = 1'b1;
      end
    end
  end

  assign sel_valid = pend && !(|active);  // One transfer in flight
  assign sel_pos   = dma_pkg::POS_W'(pick);
  assign sel_desc  = desc[pick];
  assign irq       = irq_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid  <= '0;
      done   <= '0;
      active <= '0;
      irq_q  <= '0;
    end else begin
      if (sel_valid) active[pick] <= 1'b1;  // Initiator latches it now
      if (done_en) begin
        valid[done_idx]  <= 1'b0;
        active[done_idx] <= 1'b0;
        done[done_idx]   <= 1'b1;
        irq_q[done_idx]  <= 1'b1;
      end
      if (start) begin  // Relaunch overrides a completion
        valid[cfg_idx] <= 1'b1;
        done[cfg_idx]  <= 1'b0;
        irq_q[cfg_idx] <= 1'b0;
      end
    end
  end

  // Completion only for an entry that was launched
  a_done_valid: assert property (@(posedge clk) disable iff (rst)
    done_en |-> valid[done_idx]);

endmodule

//--- hdl/dma_initiator.sv
module dma_initiator #(
  parameter logic [dma_pkg::TILE_W-1:0] TILE_ID = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  dma_pkg::desc_t            sel_desc,
  input  logic                      sel_valid,
  input  logic [dma_pkg::POS_W-1:0] sel_pos,
  output dma_pkg::flit_t            noc_out,
  output logic                      noc_out_valid,
  input  logic                      noc_out_ready,
  output logic                      done_en,
  output logic [dma_pkg::POS_W-1:0] done_pos,
  output dma_pkg::bus_req_t         bus_req,
  input  dma_pkg::bus_rsp_t         bus_rsp
);

  typedef enum logic [2:0] {
    IDLE,
    HDR,   // Header flit out
    ADDR,  // Remote address flit out
    READ,  // Local word fetch
    SEND   // Data flit out
  } state_t;

  state_t                       state;
  dma_pkg::desc_t               desc_q;
  logic [dma_pkg::POS_W-1:0]    pos_q;
  logic [dma_pkg::LEN_W-1:0]    cnt;     // Word index
  logic [dma_pkg::DATA_W-1:0]   word_q;  // Fetched word, held until sent
  dma_pkg::hdr_t                hdr;
  logic                         last_word;
  logic                         no_data;
  logic                         fire;

  assign fire      = noc_out_valid && noc_out_ready;
  assign last_word = (cnt == desc_q.len - 1'b1);
  assign no_data   = (desc_q.len == '0);  // Packet ends after address flit

  assign hdr.dest = desc_q.dest;
  assign hdr.src  = TILE_ID;
  assign hdr.rsvd = '0;
  assign hdr.len  = desc_q.len;

  ////////////////////////////////
  // FSM
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (sel_valid) state <= HDR;
        HDR:  if (fire) state <= ADDR;
        ADDR: if (fire) state <= no_data ? IDLE : READ;
        READ: if (bus_rsp.ready) state <= SEND;
        SEND: if (fire) state <= last_word ? IDLE : READ;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && sel_valid) begin  // Table marks it active here
      desc_q <= sel_desc;
      pos_q  <= sel_pos;
      cnt    <= '0;
    end
    if (state == READ && bus_rsp.ready) word_q <= bus_rsp.rdata;
    if (state == SEND && fire) cnt <= cnt + 1'b1;
  end

  ////////////////////////////////
  // Outputs
  ////////////////////////////////

  // All from registers, so a stalled flit stays put
  always_comb begin
    noc_out       = '0;
    noc_out_valid = 1'b0;
    case (state)
      HDR: begin
        noc_out.first = 1'b1;
        noc_out.data  = hdr;
        noc_out_valid = 1'b1;
      end
      ADDR: begin
        noc_out.last  = no_data;
        noc_out.data  = desc_q.raddr;
        noc_out_valid = 1'b1;
      end
      SEND: begin
        noc_out.last  = last_word;
        noc_out.data  = word_q;
        noc_out_valid = 1'b1;
      end
      default: ;
    endcase
  end

  assign done_en  = fire && ((state == SEND && last_word) || (state == ADDR && no_data));
  assign done_pos = pos_q;

  always_comb begin
    bus_req       = '0;
    bus_req.sel   = (state == READ);   // No read while a flit waits
    bus_req.lock  = (state != IDLE);   // Whole packet
    bus_req.addr  = desc_q.laddr + dma_pkg::ADDR_W'({cnt, 2'b00});
  end

  // Stalled flit holds across the link
  a_hold_flit: assert property (@(posedge clk) disable iff (rst)
    noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out));

endmodule

//--- hdl/dma_target.sv
module dma_target (
  input  logic              clk,
  input  logic              rst,
  input  dma_pkg::flit_t    noc_in,
  input  logic              noc_in_valid,
  output logic              noc_in_ready,
  output dma_pkg::bus_req_t bus_req,
  input  dma_pkg::bus_rsp_t bus_rsp
);

  typedef enum logic [1:0] {
    IDLE,   // Waiting for a header
    ADDR,   // Waiting for the address flit
    DATA,   // Waiting for a data flit
    WRITE   // Bus write pending
  } state_t;

  state_t                     state;
  logic                       rdy;
  logic [dma_pkg::LEN_W-1:0]  rem;      // Words still to come
  logic [dma_pkg::ADDR_W-1:0] waddr;
  logic [dma_pkg::DATA_W-1:0] wdata_q;
  logic                       last_q;
  dma_pkg::hdr_t              hdr_in;
  logic                       xfer;

  assign noc_in_ready = rdy;
  assign xfer         = noc_in_valid && rdy;
  assign hdr_in       = noc_in.data;

  ////////////////////////////////
  // FSM
  ////////////////////////////////

  // rdy low out of reset, low again for each bus write
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      rdy   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          rdy <= 1'b1;
          if (xfer && noc_in.first) state <= ADDR;  // Stray flits dropped
        end
        ADDR: begin
          if (xfer) state <= (rem == '0 || noc_in.last) ? IDLE : DATA;
        end
        DATA: begin
          if (xfer) begin
            rdy   <= 1'b0;
            state <= WRITE;
          end
        end
        WRITE: begin
          if (bus_rsp.ready) begin
            rdy   <= 1'b1;
            state <= last_q ? IDLE : DATA;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && xfer) rem <= hdr_in.len;
    if (state == ADDR && xfer) waddr <= noc_in.data;
    if (state == DATA && xfer) begin
      wdata_q <= noc_in.data;
      last_q  <= noc_in.last || (rem == 1);  // Either marker ends it
      rem     <= rem - 1'b1;
    end
    if (state == WRITE && bus_rsp.ready) waddr <= waddr + 4;  // Next word
  end

  always_comb begin
    bus_req       = '0;
    bus_req.sel   = (state == WRITE);
    bus_req.write = 1'b1;
    bus_req.lock  = (state != IDLE);  // Header to final write
    bus_req.addr  = waddr;
    bus_req.wdata = wdata_q;
  end

  // Sender must open each packet with a header
  a_first_in_idle: assert property (@(posedge clk) disable iff (rst)
    (state == IDLE && xfer) |-> noc_in.first);

endmodule

//--- hdl/dma_bus_arbiter.sv
module dma_bus_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  dma_pkg::bus_req_t init_req,
  output dma_pkg::bus_rsp_t init_rsp,
  input  dma_pkg::bus_req_t tgt_req,
  output dma_pkg::bus_rsp_t tgt_rsp,
  output dma_pkg::bus_req_t mem_req,
  input  dma_pkg::bus_rsp_t mem_rsp
);

  typedef enum logic {
    GNT_TGT,
    GNT_INIT
  } gnt_t;

  gnt_t gnt;
  gnt_t nxt_gnt;
  logic owner_lock;

  ////////////////////////////////
  // Grant
  ////////////////////////////////

  assign owner_lock = (gnt == GNT_TGT) ? tgt_req.lock : init_req.lock;

  // Locked owner keeps it, else target before initiator
  always_comb begin
    if (owner_lock) begin
      nxt_gnt = gnt;
    end else if (tgt_req.lock) begin
      nxt_gnt = GNT_TGT;
    end else if (init_req.lock) begin
      nxt_gnt = GNT_INIT;
    end else begin
      nxt_gnt = GNT_TGT;  // Parked on the target
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gnt <= GNT_TGT;
    end else begin
      gnt <= nxt_gnt;
    end
  end

  ////////////////////////////////
  // Request and response routing
  ////////////////////////////////

  assign mem_req = (gnt == GNT_TGT) ? tgt_req : init_req;

  always_comb begin
    init_rsp = '0;  // Loser sees ready low
    tgt_rsp  = '0;
    if (gnt == GNT_TGT) begin
      tgt_rsp = mem_rsp;
    end else begin
      init_rsp = mem_rsp;
    end
  end

  a_one_ready: assert property (@(posedge clk) disable iff (rst)
    !(init_rsp.ready && tgt_rsp.ready));

  // Masters only access the bus under their own lock
  a_sel_locked: assert property (@(posedge clk) disable iff (rst)
    mem_req.sel |-> mem_req.lock);

endmodule

//--- hdl/dma_top.sv
module dma_top #(
  parameter int                         TABLE_ENTRIES = 4,
  parameter logic [dma_pkg::TILE_W-1:0] TILE_ID       = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  dma_pkg::bus_req_t        cfg_req,
  output dma_pkg::bus_rsp_t        cfg_rsp,
  output dma_pkg::flit_t           noc_out,
  output logic                     noc_out_valid,
  input  logic                     noc_out_ready,
  input  dma_pkg::flit_t           noc_in,
  input  logic                     noc_in_valid,
  output logic                     noc_in_ready,
  output dma_pkg::bus_req_t        mem_req,
  input  dma_pkg::bus_rsp_t        mem_rsp,
  output logic [TABLE_ENTRIES-1:0] irq
);

  // Table to initiator
  dma_pkg::desc_t            sel_desc;
  logic                      sel_valid;
  logic [dma_pkg::POS_W-1:0] sel_pos;
  logic                      done_en;
  logic [dma_pkg::POS_W-1:0] done_pos;

  // Engines to arbiter
  dma_pkg::bus_req_t init_req;
  dma_pkg::bus_rsp_t init_rsp;
  dma_pkg::bus_req_t tgt_req;
  dma_pkg::bus_rsp_t tgt_rsp;

  dma_request_table #(
    .TABLE_ENTRIES(TABLE_ENTRIES)
  ) u_table (
    .clk      (clk),
    .rst      (rst),
    .cfg_req  (cfg_req),
    .cfg_rsp  (cfg_rsp),
    .sel_desc (sel_desc),
    .sel_valid(sel_valid),
    .sel_pos  (sel_pos),
    .done_en  (done_en),
    .done_pos (done_pos),
    .irq      (irq)
  );

  dma_initiator #(
    .TILE_ID(TILE_ID)
  ) u_initiator (
    .clk          (clk),
    .rst          (rst),
    .sel_desc     (sel_desc),
    .sel_valid    (sel_valid),
    .sel_pos      (sel_pos),
    .noc_out      (noc_out),
    .noc_out_valid(noc_out_valid),
    .noc_out_ready(noc_out_ready),
    .done_en      (done_en),
    .done_pos     (done_pos),
    .bus_req      (init_req),
    .bus_rsp      (init_rsp)
  );

  dma_target u_target (
    .clk         (clk),
    .rst         (rst),
    .noc_in      (noc_in),
    .noc_in_valid(noc_in_valid),
    .noc_in_ready(noc_in_ready),
    .bus_req     (tgt_req),
    .bus_rsp     (tgt_rsp)
  );

  dma_bus_arbiter u_arbiter (
    .clk     (clk),
    .rst     (rst),
    .init_req(init_req),
    .init_rsp(init_rsp),
    .tgt_req (tgt_req),
    .tgt_rsp (tgt_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

//--- verif/dma_mem_model.sv
module dma_mem_model #(
  parameter int WORDS = 256,
  parameter int SEED  = 54
) (
  input  logic              clk,
  input  logic              rst,
  input  dma_pkg::bus_req_t req,
  output dma_pkg::bus_rsp_t rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_W = $clog2(WORDS);

  logic [dma_pkg::DATA_W-1:0] mem [WORDS];  // Preloaded by the testbench
  logic [IDX_W-1:0]           idx;
  logic                       busy;       // Access armed, wait states counting
  logic [1:0]                 wait_left;
  integer                     seed = SEED;

  assign idx       = req.addr[IDX_W+1:2];  // Word index
  assign rsp.ready = req.sel && busy && (wait_left == 2'd0);
  assign rsp.rdata = mem[idx];

  ////////////////////////////////
  // Wait states and write port
  ////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      wait_left <= 2'd0;
    end else if (req.sel) begin
      if (!busy) begin
        busy      <= 1'b1;
        wait_left <= 2'($random(seed));  // 0 to 3 extra cycles
      end else if (wait_left != 2'd0) begin
        wait_left <= wait_left - 2'd1;
      end else begin
        busy <= 1'b0;  // Ready this cycle
        if (req.write) mem[idx] <= req.wdata;
      end
    end
  end

endmodule

//--- verif/dma_tb.sv
module dma_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int         ENTRIES = 4;
  localparam logic [7:0] TILE_ID = 8'h15;
  localparam int         WORDS   = 256;
  localparam int         TIMEOUT = 500;  // Cycles per wait loop

  logic               clk;
  logic               rst;
  dma_pkg::bus_req_t  cfg_req;
  dma_pkg::bus_rsp_t  cfg_rsp;
  dma_pkg::flit_t     noc_out;
  logic               noc_out_valid;
  logic               noc_out_ready;
  dma_pkg::flit_t     noc_in;
  logic               noc_in_valid;
  logic               noc_in_ready;
  dma_pkg::bus_req_t  mem_req;
  dma_pkg::bus_rsp_t  mem_rsp;
  logic [ENTRIES-1:0] irq;

  integer         seed = 54;
  int             errors = 0;
  int             failed_tests = 0;
  logic [31:0]    exp_mem [WORDS];  // Expected memory image
  dma_pkg::flit_t got_flits [$];    // Flits taken from noc_out
  logic [31:0]    rd;

  dma_top #(.TABLE_ENTRIES(ENTRIES), .TILE_ID(TILE_ID)) UUT (.*);

  dma_mem_model #(.WORDS(WORDS), .SEED(54)) u_mem (
    .clk(clk),
    .rst(rst),
    .req(mem_req),
    .rsp(mem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////
  // Helpers
  ////////////////////////////////

  function automatic logic [31:0] fill_word(input int idx);
    fill_word = 32'hc3000000 ^ (idx << 12) ^ (idx * 7);  // Unique per word
  endfunction

  function automatic logic [31:0] ctrl_word(input bit start, input logic [7:0] dest,
                                            input logic [7:0] len);
    ctrl_word = {start, 15'b0, dest, len};  // Start in bit 31
  endfunction

  task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic timeout_seen(input string what);
    $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
    errors++;
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("PASS  %s", name);
    end else begin
      failed_tests++;
      $display("FAIL  %s, %0d errors", name, errors - err0);
    end
  endtask

  // One config bus access with sel high for exactly one cycle
  task automatic reg_access(input int pos, input logic [3:0] off, input bit wr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    dma_pkg::bus_req_t req;
    req       = '0;
    req.sel   = 1'b1;
    req.write = wr;
    req.addr  = 32'(pos * 16 + int'(off));
    req.wdata = wdata;
    @(posedge clk);
    cfg_req <= req;
    @(negedge clk);
    rdata = cfg_rsp.rdata;  // Same cycle read
    if (cfg_rsp.ready !== 1'b1) begin
      $display("FAILED at %0t ns: cfg_rsp.ready is %b during an access", $time, cfg_rsp.ready);
      errors++;
    end
    @(posedge clk);         // Write lands on this edge
    cfg_req <= '0;
  endtask

  task automatic write_desc(input int pos, input logic [31:0] laddr, input logic [31:0] raddr,
                            input logic [7:0] dest, input logic [7:0] len, input bit start);
    reg_access(pos, dma_pkg::REG_LADDR, 1'b1, laddr, rd);
    reg_access(pos, dma_pkg::REG_RADDR, 1'b1, raddr, rd);
    reg_access(pos, dma_pkg::REG_CTRL_LEN, 1'b1, ctrl_word(start, dest, len), rd);
  endtask

  // Takes count flits off noc_out with ready random or held high
  task automatic collect_flits(input int count, input bit random_ready);
    dma_pkg::flit_t held;
    bit             stalled = 1'b0;
    int             t = 0;
    got_flits.delete();
    while (got_flits.size() < count && t < TIMEOUT) begin
      @(posedge clk);
      noc_out_ready <= random_ready ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
      t++;
      if (stalled && !(noc_out_valid && noc_out === held)) begin
        $display("FAILED at %0t ns: stalled flit changed to %h", $time, noc_out);
        errors++;
      end
      stalled = noc_out_valid && !noc_out_ready;
      held    = noc_out;
      if (noc_out_valid && noc_out_ready) got_flits.push_back(noc_out);
    end
    if (got_flits.size() < count) timeout_seen("flits on noc_out");
    @(posedge clk);  // Last flit transfers here
    noc_out_ready <= 1'b0;
  endtask

  // Header and address then one flit per local word with last on the final one
  task automatic check_out_packet(input logic [7:0] dest, input logic [31:0] raddr,
                                  input int len, input int lword);
    dma_pkg::hdr_t hdr;
    hdr.dest = dest;
    hdr.src  = TILE_ID;
    hdr.rsvd = '0;
    hdr.len  = 8'(len);
    if (got_flits.size() != len + 2) begin
      $display("FAILED at %0t ns: %0d flits, expected %0d", $time, got_flits.size(), len + 2);
      errors++;
    end else begin
      compare_word(got_flits[0].data, hdr, "header flit");
      compare_word(32'({got_flits[0].first, got_flits[0].last}), 32'h2, "header flags");
      compare_word(got_flits[1].data, raddr, "address flit");
      compare_word(32'({got_flits[1].first, got_flits[1].last}), 32'h0, "address flags");
      for (int i = 0; i < len; i++) begin
        compare_word(got_flits[i+2].data, exp_mem[lword+i], $sformatf("data flit %0d", i));
        compare_word(32'({got_flits[i+2].first, got_flits[i+2].last}), 32'(i == len - 1),
                     $sformatf("data flags %0d", i));
      end
    end
  endtask

  task automatic send_packet(input logic [31:0] raddr, input int count);
    dma_pkg::flit_t flits [$];
    dma_pkg::flit_t f;
    dma_pkg::hdr_t  hdr;
    int             gap;
    int             t;
    hdr.dest = TILE_ID;
    hdr.src  = 8'h42;  // Some remote tile
    hdr.rsvd = '0;
    hdr.len  = 8'(count);
    f = '{first: 1'b1, last: 1'b0, data: hdr};
    flits.push_back(f);
    f = '{first: 1'b0, last: (count == 0), data: raddr};
    flits.push_back(f);
    for (int i = 0; i < count; i++) begin
      f = '{first: 1'b0, last: (i == count - 1), data: $random(seed)};
      exp_mem[int'(raddr[9:2]) + i] = f.data;  // Consecutive words
      flits.push_back(f);
    end
    foreach (flits[i]) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk);
        noc_in_valid <= 1'b0;
      end
      @(posedge clk);
      noc_in       <= flits[i];
      noc_in_valid <= 1'b1;
      t = 0;
      do begin
        @(negedge clk);
        t++;
      end while (!noc_in_ready && t < TIMEOUT);
      if (!noc_in_ready) timeout_seen("noc_in_ready");
    end
    @(posedge clk);
    noc_in_valid <= 1'b0;
    t = 0;
    do begin  // Ready returns once the final write is done
      @(negedge clk);
      t++;
    end while (!noc_in_ready && t < TIMEOUT);
    if (!noc_in_ready) timeout_seen("end of incoming packet");
  endtask

  task automatic wait_irq(input int pos);
    int t = 0;
    while (!irq[pos] && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!irq[pos]) timeout_seen($sformatf("irq[%0d]", pos));
  endtask

  task automatic check_memory();
    for (int i = 0; i < WORDS; i++) begin
      compare_word(u_mem.mem[i], exp_mem[i], $sformatf("memory word %0d", i));
    end
  endtask

  ////////////////////////////////
  // Directed tests
  ////////////////////////////////

  task automatic test_reset_state();
    int err0 = errors;
    @(negedge clk);  // First cycle out of reset
    compare_word(32'(noc_out_valid), 32'h0, "noc_out_valid");
    compare_word(32'(noc_in_ready), 32'h0, "noc_in_ready");
    compare_word(32'(irq), 32'h0, "irq");
    compare_word(32'(mem_req.sel), 32'h0, "mem_req.sel");
    for (int i = 0; i < ENTRIES; i++) begin
      reg_access(i, dma_pkg::REG_STATUS, 1'b0, 32'h0, rd);
      compare_word(rd, 32'h0, $sformatf("status %0d", i));
    end
    report_test("reset state", err0);
  endtask

  task automatic test_descriptors();
    int err0 = errors;
    write_desc(0, 32'h40, 32'h1234_5670, 8'h21, 8'd4, 1'b0);
    write_desc(1, 32'h80, 32'h0bad_0100, 8'h07, 8'd3, 1'b0);
    reg_access(0, dma_pkg::REG_LADDR, 1'b0, 32'h0, rd);
    compare_word(rd, 32'h40, "entry 0 laddr");
    reg_access(0, dma_pkg::REG_RADDR, 1'b0, 32'h0, rd);
    compare_word(rd, 32'h1234_5670, "entry 0 raddr");
    reg_access(0, dma_pkg::REG_CTRL_LEN, 1'b0, 32'h0, rd);
    compare_word(rd, ctrl_word(1'b0, 8'h21, 8'd4), "entry 0 ctrl");
    reg_access(1, dma_pkg::REG_LADDR, 1'b0, 32'h0, rd);
    compare_word(rd, 32'h80, "entry 1 laddr");
    reg_access(1, dma_pkg::REG_RADDR, 1'b0, 32'h0, rd);
    compare_word(rd, 32'h0bad_0100, "entry 1 raddr");
    reg_access(1, dma_pkg::REG_CTRL_LEN, 1'b0, 32'h0, rd);
    compare_word(rd, ctrl_word(1'b0, 8'h07, 8'd3), "entry 1 ctrl");
    report_test("descriptor readback", err0);
  endtask

  // Entry 0 moves four words from word 16
  task automatic test_outgoing(input bit random_ready, input string name);
    int err0 = errors;
    reg_access(0, dma_pkg::REG_CTRL_LEN, 1'b1, ctrl_word(1'b1, 8'h21, 8'd4), rd);
    collect_flits(6, random_ready);
    check_out_packet(8'h21, 32'h1234_5670, 4, 16);
    wait_irq(0);
    reg_access(0, dma_pkg::REG_STATUS, 1'b0, 32'h0, rd);
    compare_word(rd, 32'h2, "status after done");  // Done and not valid
    report_test(name, err0);
  endtask

  task automatic test_incoming();
    int err0 = errors;
    send_packet(32'h200, 3);
    check_memory();
    report_test("incoming packet", err0);
  endtask

  task automatic test_concurrent();
    int err0 = errors;
    reg_access(1, dma_pkg::REG_CTRL_LEN, 1'b1, ctrl_word(1'b1, 8'h07, 8'd3), rd);
    fork
      collect_flits(5, 1'b1);
      send_packet(32'h300, 3);
    join
    check_out_packet(8'h07, 32'h0bad_0100, 3, 32);
    wait_irq(1);
    reg_access(1, dma_pkg::REG_STATUS, 1'b0, 32'h0, rd);
    compare_word(rd, 32'h2, "entry 1 status");
    check_memory();  // Also catches stray writes
    report_test("concurrent transfers", err0);
  endtask

  initial begin
    rst           = 1'b1;
    cfg_req       = '0;
    noc_out_ready = 1'b0;
    noc_in        = '0;
    noc_in_valid  = 1'b0;
    for (int i = 0; i < WORDS; i++) begin
      exp_mem[i]    = fill_word(i);
      u_mem.mem[i]  = fill_word(i);
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_descriptors();
    test_outgoing(1'b0, "outgoing transfer");
    test_outgoing(1'b1, "outgoing with back-pressure");
    test_incoming();
    test_concurrent();
    $display("Summary: 6 tests, %0d failed, %0d errors", failed_tests, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sources.f
hdl/dma_pkg.sv
hdl/dma_request_table.sv
hdl/dma_initiator.sv
hdl/dma_target.sv
hdl/dma_bus_arbiter.sv
hdl/dma_top.sv
verif/dma_mem_model.sv
verif/dma_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --timing --assert -Wno-fatal
TOP      := dma_tb
FILELIST := sources.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD)/V$(TOP): $(shell cat $(FILELIST))
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
